//--- rtl/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction word
`define INST_W 32

// register file index
`define REG_ADDR_W 5

// mcause exception code, interrupts not handled
`define MCAUSE_W 4

// privilege level as seen by the csr file
`define PRV_W 2

// next-pc mux select
`define PC_SRC_W 3

// writeback data mux select
`define WB_SRC_W 2

`endif

//--- rtl/rv32_pkg.sv
`include "ctrl_params.svh"

package rv32_pkg;

  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`PRV_W-1:0] prv_t; // 0 = user, 3 = machine

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_OP_IMM   = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_OP       = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // exception causes
  // ecall from S/M is reached by adding the privilege level
  typedef enum logic [`MCAUSE_W-1:0] {
    MCAUSE_INST_ADDR_MISALIGNED  = 4'd0, // also used for fetch bus errors
    MCAUSE_ILLEGAL_INST          = 4'd2,
    MCAUSE_BREAKPOINT            = 4'd3,
    MCAUSE_LOAD_ADDR_MISALIGNED  = 4'd4,
    MCAUSE_STORE_ADDR_MISALIGNED = 4'd6,
    MCAUSE_ECALL_FROM_U          = 4'd8
  } mcause_e;

endpackage

//--- rtl/pipe_ctrl_pkg.sv
`include "ctrl_params.svh"

package pipe_ctrl_pkg;

  typedef enum logic [`PC_SRC_W-1:0] {
    PC_PLUS_FOUR,
    PC_BRANCH_TARGET,
    PC_MISSED_PREDICT, // predicted taken, fell through
    PC_JAL_TARGET,
    PC_JALR_TARGET,
    PC_EPC,
    PC_HANDLER
  } pc_src_e;

  typedef enum logic [`WB_SRC_W-1:0] {
    WB_SRC_ALU,
    WB_SRC_PC,
    WB_SRC_DMEM,
    WB_SRC_CSR
  } wb_src_e;

  // ahb htrans, only single transfers
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10
  } htrans_e;

  // decoder flags for the dx instruction, not yet killed
  typedef struct packed {
    logic    jal;
    logic    jalr;
    logic    eret;
    logic    wr_reg;
    logic    dmem_en;
    logic    dmem_wen;
    logic    uses_rs1;
    logic    uses_rs2;
    logic    uses_rs3;
    logic    ecall;
    logic    ebreak;
    logic    illegal;
    logic    illegal_csr;
    wb_src_e wb_src;
  } ex_ctrl_t;

  typedef struct packed {
    logic              valid;
    rv32_pkg::mcause_e cause;
  } trap_t;

  // dx -> wb pipeline record
  typedef struct packed {
    logic                wr_reg;
    rv32_pkg::reg_addr_t rd;
    wb_src_e             wb_src;
    logic                dmem_en;
    logic                store;
    logic                bubble;
    trap_t               trap;
  } wb_entry_t;

  // wb -> dx feedback
  typedef struct packed {
    logic                wr_reg_unkilled;
    rv32_pkg::reg_addr_t rd;
    logic                load;
    logic                dmem_en;
    logic                ex_wb;
    logic                ex_wb_r; // ex_wb one cycle late
    logic                stall_wb;
  } wb_status_t;

  typedef struct packed {
    logic rs3;
    logic rs2;
    logic rs1;
  } bypass_t;

endpackage

//--- rtl/operand_hazard.sv
`timescale 1ns/10ps

`include "ctrl_params.svh"

module operand_hazard (
  input  logic [`INST_W-1:0]        inst_ex_i,
  input  logic [2:0]                uses_rs_i, // {rs3, rs2, rs1}
  input  pipe_ctrl_pkg::wb_status_t wb_i,
  output pipe_ctrl_pkg::bypass_t    bypass_o,
  output logic                      load_use_o
);

  rv32_pkg::reg_addr_t [2:0] rs_addr;
  logic [2:0]                raw;
  logic [2:0]                fwd;

  // source fields, rs3 sits in the r4-type funct5 slot
  assign rs_addr[0] = inst_ex_i[19:15];
  assign rs_addr[1] = inst_ex_i[24:20];
  assign rs_addr[2] = inst_ex_i[31:27];

  // same compare for each source
  for (genvar i = 0; i < 3; i++) begin : g_raw
    assign raw[i] = wb_i.wr_reg_unkilled &&
                    (rs_addr[i] == wb_i.rd) &&
                    (rs_addr[i] != '0) &&      // x0 never forwarded
                    uses_rs_i[i];
    assign fwd[i] = raw[i] && !wb_i.load;      // alu result is ready in wb
  end

  assign bypass_o.rs1 = fwd[0];
  assign bypass_o.rs2 = fwd[1];
  assign bypass_o.rs3 = fwd[2];

  // load data only arrives at the end of wb, so the consumer has to wait
  assign load_use_o = wb_i.load && (|raw);

endmodule

//--- rtl/branch_resolve.sv
`timescale 1ns/10ps

`include "ctrl_params.svh"

module branch_resolve (
  input  logic [`INST_W-1:0]       inst_ex_i,
  input  pipe_ctrl_pkg::ex_ctrl_t  ctrl_i,
  input  logic                     cmp_true_i,
  input  logic                     predicted_i,
  input  logic                     stall_ex_i,
  input  logic                     kill_ex_i,
  input  logic                     ex_wb_i,
  output logic                     redirect_o,
  output pipe_ctrl_pkg::pc_src_e   pc_src_o
);

  rv32_pkg::opcode_e opcode;
  logic              taken_unkilled;
  logic              taken;
  logic              eret;
  logic              jal;
  logic              jalr;

  assign opcode = rv32_pkg::opcode_e'(inst_ex_i[6:0]);

  assign taken_unkilled = (opcode == rv32_pkg::OP_BRANCH) && cmp_true_i;

  // killed copies feed the pc mux
  assign taken = taken_unkilled && !kill_ex_i;
  assign eret  = ctrl_i.eret    && !kill_ex_i;
  assign jal   = ctrl_i.jal     && !kill_ex_i;
  assign jalr  = ctrl_i.jalr    && !kill_ex_i;

  // fetch already ran ahead on the prediction, anything else is a redirect
  assign redirect_o = !stall_ex_i &&
                      ((predicted_i && !taken_unkilled && !ctrl_i.jal) ||
                       (taken_unkilled && !predicted_i) ||
                       ctrl_i.eret || ctrl_i.jal || ctrl_i.jalr);

  always_comb begin
    if (ex_wb_i) begin
      pc_src_o = pipe_ctrl_pkg::PC_HANDLER;        // trap wins over everything in dx
    end else if (eret) begin
      pc_src_o = pipe_ctrl_pkg::PC_EPC;
    end else if (taken && !predicted_i) begin
      pc_src_o = pipe_ctrl_pkg::PC_BRANCH_TARGET;
    end else if (!taken && predicted_i) begin
      pc_src_o = pipe_ctrl_pkg::PC_MISSED_PREDICT;
    end else if (jal) begin
      pc_src_o = pipe_ctrl_pkg::PC_JAL_TARGET;
    end else if (jalr) begin
      pc_src_o = pipe_ctrl_pkg::PC_JALR_TARGET;
    end else begin
      pc_src_o = pipe_ctrl_pkg::PC_PLUS_FOUR;
    end
  end

endmodule

//--- rtl/ex_stage_ctrl.sv
`timescale 1ns/10ps

`include "ctrl_params.svh"

module ex_stage_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`INST_W-1:0]        inst_ex_i,
  input  logic                      if_valid_i,
  input  logic                      de_ready_i,
  input  logic                      ex_valid_i,
  input  logic                      ex_ready_i,
  input  logic                      imem_badmem_i,
  input  logic                      dmem_hready_i,
  input  pipe_ctrl_pkg::ex_ctrl_t   ctrl_i,
  input  rv32_pkg::prv_t            prv_i,
  input  logic                      load_use_i,
  input  pipe_ctrl_pkg::wb_status_t wb_i,
  input  logic                      redirect_i,
  output logic                      stall_ex_o,
  output logic                      kill_ex_o,
  output logic                      dmem_wen_o,
  output pipe_ctrl_pkg::htrans_e    htrans_o,
  output pipe_ctrl_pkg::wb_entry_t  entry_o
);

  logic                 had_ex_de;
  logic                 had_ex_ex;
  logic                 ex_ex;
  logic                 dmem_en;
  logic                 flush;
  pipe_ctrl_pkg::trap_t trap_ex;

  assign flush = wb_i.ex_wb || redirect_i;

  // fetch error enters decode together with its instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      had_ex_de <= 1'b0;
    end else if (!flush && de_ready_i && if_valid_i) begin
      had_ex_de <= imem_badmem_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      had_ex_ex <= 1'b0;
    end else if (!stall_ex_o) begin
      had_ex_ex <= had_ex_de;
    end
  end

  assign ex_ex = had_ex_ex || ctrl_i.illegal || ctrl_i.illegal_csr ||
                 ctrl_i.ebreak || ctrl_i.ecall;

  // cause priority
  always_comb begin
    trap_ex.valid = ex_ex;
    trap_ex.cause = rv32_pkg::MCAUSE_INST_ADDR_MISALIGNED;
    if (had_ex_ex) begin
      trap_ex.cause = rv32_pkg::MCAUSE_INST_ADDR_MISALIGNED;
    end else if (ctrl_i.illegal || ctrl_i.illegal_csr) begin
      trap_ex.cause = rv32_pkg::MCAUSE_ILLEGAL_INST;
    end else if (ctrl_i.ebreak) begin
      trap_ex.cause = rv32_pkg::MCAUSE_BREAKPOINT;
    end else if (ctrl_i.ecall) begin
      trap_ex.cause = rv32_pkg::mcause_e'(rv32_pkg::MCAUSE_ECALL_FROM_U + `MCAUSE_W'(prv_i));
    end
  end

  assign dmem_en    = ctrl_i.dmem_en && !wb_i.ex_wb;
  assign dmem_wen_o = ctrl_i.dmem_wen && !wb_i.ex_wb && ex_ready_i;
  assign htrans_o   = dmem_en ? pipe_ctrl_pkg::HTRANS_NONSEQ : pipe_ctrl_pkg::HTRANS_IDLE;

  // a trapping instruction never waits on a hazard
  assign stall_ex_o = wb_i.stall_wb ||
                      (dmem_en && !dmem_hready_i) ||
                      (load_use_i && !(ex_ex || wb_i.ex_wb || wb_i.ex_wb_r));

  assign kill_ex_o = stall_ex_o || ex_ex || wb_i.ex_wb;

  always_comb begin
    entry_o.wr_reg     = ctrl_i.wr_reg && !kill_ex_o;
    entry_o.rd         = inst_ex_i[11:7];
    entry_o.wb_src     = ctrl_i.wb_src;
    entry_o.dmem_en    = dmem_en;
    entry_o.store      = dmem_wen_o;
    entry_o.bubble     = kill_ex_o || !ex_valid_i;
    // the dx trap itself is part of kill, so only the other kill sources drop it
    entry_o.trap.valid = trap_ex.valid && !stall_ex_o && !wb_i.ex_wb;
    entry_o.trap.cause = trap_ex.cause;
  end

endmodule

//--- rtl/wb_stage_ctrl.sv
`timescale 1ns/10ps

module wb_stage_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  pipe_ctrl_pkg::wb_entry_t  entry_i,
  input  logic                      dmem_hready_i,
  input  logic                      dmem_badmem_i,
  input  logic                      redirect_i,
  output pipe_ctrl_pkg::wb_status_t status_o,
  output logic                      flush_o,
  output logic                      wr_reg_wb_o,
  output rv32_pkg::reg_addr_t       rd_wb_o,
  output pipe_ctrl_pkg::wb_src_e    wb_src_o,
  output pipe_ctrl_pkg::trap_t      exception_o,
  output logic                      retire_o
);

  pipe_ctrl_pkg::wb_entry_t wb_q;
  logic                     ex_wb;
  logic                     ex_wb_r;
  logic                     stall_wb;
  logic                     kill_wb;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_q.wr_reg     <= 1'b0;
      wb_q.rd         <= '0;
      wb_q.wb_src     <= pipe_ctrl_pkg::WB_SRC_ALU;
      wb_q.dmem_en    <= 1'b0;
      wb_q.store      <= 1'b0;
      wb_q.bubble     <= 1'b1; // nothing to retire out of reset
      wb_q.trap.valid <= 1'b0;
      wb_q.trap.cause <= rv32_pkg::MCAUSE_INST_ADDR_MISALIGNED;
    end else if (!stall_wb) begin
      wb_q <= entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_wb_r <= 1'b0;
    end else begin
      ex_wb_r <= ex_wb;
    end
  end

  assign ex_wb    = wb_q.trap.valid || dmem_badmem_i;
  assign stall_wb = !dmem_hready_i && wb_q.dmem_en && !ex_wb; // data phase still open
  assign kill_wb  = stall_wb || ex_wb;

  // a bus error on the data phase, load if the entry writes a register
  always_comb begin
    exception_o.valid = ex_wb;
    exception_o.cause = wb_q.trap.cause;
    if (!wb_q.trap.valid && dmem_badmem_i) begin
      exception_o.cause = wb_q.wr_reg ? rv32_pkg::MCAUSE_LOAD_ADDR_MISALIGNED :
                                        rv32_pkg::MCAUSE_STORE_ADDR_MISALIGNED;
    end
  end

  assign flush_o     = ex_wb || redirect_i;
  assign wr_reg_wb_o = wb_q.wr_reg && !kill_wb && !wb_q.bubble;
  assign retire_o    = !(kill_wb || wb_q.bubble);
  assign rd_wb_o     = wb_q.rd;
  assign wb_src_o    = wb_q.wb_src;

  always_comb begin
    status_o.wr_reg_unkilled = wb_q.wr_reg;
    status_o.rd              = wb_q.rd;
    status_o.load            = wb_q.dmem_en && !wb_q.store;
    status_o.dmem_en         = wb_q.dmem_en;
    status_o.ex_wb           = ex_wb;
    status_o.ex_wb_r         = ex_wb_r;
    status_o.stall_wb        = stall_wb;
  end

endmodule

//--- rtl/pipeline_ctrl.sv
`timescale 1ns/10ps

`include "ctrl_params.svh"

module pipeline_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`INST_W-1:0]       inst_ex_i,
  input  pipe_ctrl_pkg::ex_ctrl_t  ex_ctrl_i,
  input  logic                     if_valid_i,
  input  logic                     de_ready_i,
  input  logic                     ex_valid_i,
  input  logic                     ex_ready_i,
  input  logic                     imem_badmem_i,
  input  logic                     dmem_badmem_i,
  input  logic                     dmem_hready_i,
  input  logic                     cmp_true_i,
  input  logic                     predicted_branch_i,
  input  rv32_pkg::prv_t           prv_i,
  // dx stage
  output pipe_ctrl_pkg::bypass_t   bypass_o,
  output logic                     load_use_o,
  output logic                     stall_ex_o,
  output logic                     kill_ex_o,
  output logic                     redirect_o,
  output pipe_ctrl_pkg::pc_src_e   pc_src_sel_o,
  output logic                     dmem_wen_o,
  output pipe_ctrl_pkg::htrans_e   dmem_htrans_o,
  // wb stage
  output logic                     flush_o,
  output logic                     wr_reg_wb_o,
  output rv32_pkg::reg_addr_t      rd_wb_o,
  output pipe_ctrl_pkg::wb_src_e   wb_src_wb_o,
  output pipe_ctrl_pkg::trap_t     exception_o,
  output logic                     retire_o
);

  pipe_ctrl_pkg::wb_status_t wb_status;
  pipe_ctrl_pkg::wb_entry_t  wb_entry;

  operand_hazard u_operand_hazard (
    .inst_ex_i  (inst_ex_i),
    .uses_rs_i  ({ex_ctrl_i.uses_rs3, ex_ctrl_i.uses_rs2, ex_ctrl_i.uses_rs1}),
    .wb_i       (wb_status),
    .bypass_o   (bypass_o),
    .load_use_o (load_use_o)
  );

  ex_stage_ctrl u_ex_stage_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .inst_ex_i     (inst_ex_i),
    .if_valid_i    (if_valid_i),
    .de_ready_i    (de_ready_i),
    .ex_valid_i    (ex_valid_i),
    .ex_ready_i    (ex_ready_i),
    .imem_badmem_i (imem_badmem_i),
    .dmem_hready_i (dmem_hready_i),
    .ctrl_i        (ex_ctrl_i),
    .prv_i         (prv_i),
    .load_use_i    (load_use_o),
    .wb_i          (wb_status),
    .redirect_i    (redirect_o),
    .stall_ex_o    (stall_ex_o),
    .kill_ex_o     (kill_ex_o),
    .dmem_wen_o    (dmem_wen_o),
    .htrans_o      (dmem_htrans_o),
    .entry_o       (wb_entry)
  );

  branch_resolve u_branch_resolve (
    .inst_ex_i   (inst_ex_i),
    .ctrl_i      (ex_ctrl_i),
    .cmp_true_i  (cmp_true_i),
    .predicted_i (predicted_branch_i),
    .stall_ex_i  (stall_ex_o),
    .kill_ex_i   (kill_ex_o),
    .ex_wb_i     (wb_status.ex_wb),
    .redirect_o  (redirect_o),
    .pc_src_o    (pc_src_sel_o)
  );

  wb_stage_ctrl u_wb_stage_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .entry_i       (wb_entry),
    .dmem_hready_i (dmem_hready_i),
    .dmem_badmem_i (dmem_badmem_i),
    .redirect_i    (redirect_o),
    .status_o      (wb_status),
    .flush_o       (flush_o),
    .wr_reg_wb_o   (wr_reg_wb_o),
    .rd_wb_o       (rd_wb_o),
    .wb_src_o      (wb_src_wb_o),
    .exception_o   (exception_o),
    .retire_o      (retire_o)
  );

endmodule

//--- test/pipeline_ctrl_model.svh
`ifndef PIPELINE_CTRL_MODEL_SVH
`define PIPELINE_CTRL_MODEL_SVH

typedef struct packed {
  logic       wr_reg;
  logic [4:0] rd;
  logic [1:0] wb_src;
  logic       dmem_en;
  logic       store;
  logic       bubble;
  logic       trap_valid;
  logic [3:0] cause;
} model_entry_t;

// state of the unit as the model sees it
model_entry_t m_wb;
logic         m_had_ex_de;
logic         m_had_ex_ex;
logic         m_ex_wb_r;

// next state, worked out in the middle of the cycle
model_entry_t n_wb;
logic         n_had_ex_de;
logic         n_had_ex_ex;
logic         n_ex_wb_r;

logic [2:0] exp_bypass; // {rs3, rs2, rs1}
logic       exp_load_use;
logic       exp_stall_ex;
logic       exp_kill_ex;
logic       exp_redirect;
logic [2:0] exp_pc_src;
logic       exp_dmem_wen;
logic [1:0] exp_htrans;
logic       exp_flush;
logic       exp_wr_reg_wb;
logic [4:0] exp_rd_wb;
logic [1:0] exp_wb_src;
logic       exp_exc_valid;
logic [3:0] exp_exc_cause;
logic       exp_retire;

task automatic model_reset();
  m_wb        = '0;
  m_wb.bubble = 1'b1;  // empty wb slot
  m_had_ex_de = 1'b0;
  m_had_ex_ex = 1'b0;
  m_ex_wb_r   = 1'b0;
endtask

task automatic model_advance();
  m_wb        = n_wb;
  m_had_ex_de = n_had_ex_de;
  m_had_ex_ex = n_had_ex_ex;
  m_ex_wb_r   = n_ex_wb_r;
endtask

task automatic model_eval();
  logic [2:0][4:0] rs;
  logic [2:0]      uses;
  logic [2:0]      raw;
  logic            load;
  logic            ex_wb;
  logic            stall_wb;
  logic            kill_wb;
  logic            dx_trap;
  logic            mem_en;
  logic            taken_u;
  logic            taken;
  logic [3:0]      cause;
  model_entry_t    e;

  // writeback side
  ex_wb         = m_wb.trap_valid || dmem_badmem;
  stall_wb      = !dmem_hready && m_wb.dmem_en && !ex_wb;
  kill_wb       = stall_wb || ex_wb;
  load          = m_wb.dmem_en && !m_wb.store;
  exp_exc_valid = ex_wb;
  if (m_wb.trap_valid) begin
    exp_exc_cause = m_wb.cause;
  end else begin
    exp_exc_cause = m_wb.wr_reg ? 4'd4 : 4'd6; // load or store fault
  end
  exp_wr_reg_wb = m_wb.wr_reg && !kill_wb && !m_wb.bubble;
  exp_retire    = !kill_wb && !m_wb.bubble;
  exp_rd_wb     = m_wb.rd;
  exp_wb_src    = m_wb.wb_src;

  // operand hazards against the wb destination
  rs[0] = inst_ex[19:15];
  rs[1] = inst_ex[24:20];
  rs[2] = inst_ex[31:27];
  uses  = {ex_ctrl.uses_rs3, ex_ctrl.uses_rs2, ex_ctrl.uses_rs1};
  for (int i = 0; i < 3; i++) begin
    raw[i] = m_wb.wr_reg && (rs[i] == m_wb.rd) && (rs[i] != 5'd0) && uses[i];
  end
  exp_bypass   = raw & {3{!load}};
  exp_load_use = load && (|raw);

  // dx stall and kill
  dx_trap = m_had_ex_ex || ex_ctrl.illegal || ex_ctrl.illegal_csr ||
            ex_ctrl.ebreak || ex_ctrl.ecall;
  mem_en  = ex_ctrl.dmem_en && !ex_wb;
  exp_stall_ex = stall_wb || (mem_en && !dmem_hready) ||
                 (exp_load_use && !(dx_trap || ex_wb || m_ex_wb_r));
  exp_kill_ex  = exp_stall_ex || dx_trap || ex_wb;
  exp_dmem_wen = ex_ctrl.dmem_wen && !ex_wb && ex_ready;
  exp_htrans   = mem_en ? 2'b10 : 2'b00;

  // branch outcome against the static prediction
  taken_u = (inst_ex[6:0] == 7'b1100011) && cmp_true;
  taken   = taken_u && !exp_kill_ex;
  exp_redirect = !exp_stall_ex &&
                 ((predicted && !taken_u && !ex_ctrl.jal) || (taken_u && !predicted) ||
                  ex_ctrl.eret || ex_ctrl.jal || ex_ctrl.jalr);
  if (ex_wb) exp_pc_src = pipe_ctrl_pkg::PC_HANDLER;
  else if (ex_ctrl.eret && !exp_kill_ex) exp_pc_src = pipe_ctrl_pkg::PC_EPC;
  else if (taken && !predicted) exp_pc_src = pipe_ctrl_pkg::PC_BRANCH_TARGET;
  else if (!taken && predicted) exp_pc_src = pipe_ctrl_pkg::PC_MISSED_PREDICT;
  else if (ex_ctrl.jal && !exp_kill_ex) exp_pc_src = pipe_ctrl_pkg::PC_JAL_TARGET;
  else if (ex_ctrl.jalr && !exp_kill_ex) exp_pc_src = pipe_ctrl_pkg::PC_JALR_TARGET;
  else exp_pc_src = pipe_ctrl_pkg::PC_PLUS_FOUR;
  exp_flush = ex_wb || exp_redirect;

  // dx trap cause by priority
  if (m_had_ex_ex) cause = 4'd0;
  else if (ex_ctrl.illegal || ex_ctrl.illegal_csr) cause = 4'd2;
  else if (ex_ctrl.ebreak) cause = 4'd3;
  else cause = 4'd8 + {2'b00, prv}; // ecall

  e.wr_reg     = ex_ctrl.wr_reg && !exp_kill_ex;
  e.rd         = inst_ex[11:7];
  e.wb_src     = ex_ctrl.wb_src;
  e.dmem_en    = mem_en;
  e.store      = exp_dmem_wen;
  e.bubble     = exp_kill_ex || !ex_valid;
  e.trap_valid = dx_trap && !exp_stall_ex && !ex_wb;
  e.cause      = cause;

  n_wb        = stall_wb ? m_wb : e;
  n_ex_wb_r   = ex_wb;
  n_had_ex_de = (!exp_flush && de_ready && if_valid) ?
                (imem_badmem && if_valid && !exp_redirect) : m_had_ex_de;
  n_had_ex_ex = exp_stall_ex ? m_had_ex_ex : m_had_ex_de;
endtask

`endif

//--- test/tb_pipeline_ctrl.sv
`timescale 1ns/10ps

`include "ctrl_params.svh"

module tb_pipeline_ctrl;

  localparam int unsigned SEED          = 32'h93ef356c;
  localparam int unsigned CLK_PERIOD_NS = 20;
  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned NUM_CYCLES    = 5000;
  localparam int unsigned TIMEOUT_NS    = (RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD_NS * 2;

  logic                    clk;
  logic                    rst_n;
  logic [`INST_W-1:0]      inst_ex;
  pipe_ctrl_pkg::ex_ctrl_t ex_ctrl;
  logic                    if_valid;
  logic                    de_ready;
  logic                    ex_valid;
  logic                    ex_ready;
  logic                    imem_badmem;
  logic                    dmem_badmem;
  logic                    dmem_hready;
  logic                    cmp_true;
  logic                    predicted;
  logic [1:0]              prv;

  logic [2:0] bypass;
  logic       load_use;
  logic       stall_ex;
  logic       kill_ex;
  logic       redirect;
  logic [2:0] pc_src_sel;
  logic       dmem_wen;
  logic [1:0] dmem_htrans;
  logic       flush;
  logic       wr_reg_wb;
  logic [4:0] rd_wb;
  logic [1:0] wb_src_wb;
  logic [4:0] exc; // {valid, cause}
  logic       retire;

  int unsigned cycle;
  int unsigned fail_count;
  int unsigned n_bypass;
  int unsigned n_load_use;
  int unsigned n_trap;
  int unsigned n_retire;

  `include "pipeline_ctrl_model.svh"

  pipeline_ctrl dut0 (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .inst_ex_i          (inst_ex),
    .ex_ctrl_i          (ex_ctrl),
    .if_valid_i         (if_valid),
    .de_ready_i         (de_ready),
    .ex_valid_i         (ex_valid),
    .ex_ready_i         (ex_ready),
    .imem_badmem_i      (imem_badmem),
    .dmem_badmem_i      (dmem_badmem),
    .dmem_hready_i      (dmem_hready),
    .cmp_true_i         (cmp_true),
    .predicted_branch_i (predicted),
    .prv_i              (prv),
    .bypass_o           (bypass),
    .load_use_o         (load_use),
    .stall_ex_o         (stall_ex),
    .kill_ex_o          (kill_ex),
    .redirect_o         (redirect),
    .pc_src_sel_o       (pc_src_sel),
    .dmem_wen_o         (dmem_wen),
    .dmem_htrans_o      (dmem_htrans),
    .flush_o            (flush),
    .wr_reg_wb_o        (wr_reg_wb),
    .rd_wb_o            (rd_wb),
    .wb_src_wb_o        (wb_src_wb),
    .exception_o        (exc),
    .retire_o           (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  function automatic bit one_in(int unsigned n);
    return ($urandom_range(n - 1) == 0);
  endfunction

  // mostly x0..x3 so sources hit the wb rd often
  function automatic logic [4:0] pick_reg();
    if ($urandom_range(3) != 0) return 5'($urandom_range(3));
    return 5'($urandom_range(31));
  endfunction

  task automatic drive_inputs();
    logic [31:0]             inst;
    logic [31:0]             bits;
    pipe_ctrl_pkg::ex_ctrl_t c;
    inst        = $urandom;
    bits        = $urandom;
    inst[11:7]  = pick_reg();
    inst[19:15] = pick_reg();
    inst[24:20] = pick_reg();
    inst[31:27] = pick_reg();
    if (one_in(3)) inst[6:0] = 7'b1100011; // conditional branch
    c.wr_reg      = bits[0];
    c.dmem_en     = bits[1] & bits[2];
    c.dmem_wen    = c.dmem_en & bits[3];
    c.uses_rs1    = bits[4] | bits[5];
    c.uses_rs2    = bits[6];
    c.uses_rs3    = bits[7] & bits[8];
    c.wb_src      = pipe_ctrl_pkg::wb_src_e'(bits[10:9]);
    c.jal         = one_in(10);
    c.jalr        = one_in(12);
    c.eret        = one_in(16);
    c.ecall       = one_in(14);
    c.ebreak      = one_in(20);
    c.illegal     = one_in(20);
    c.illegal_csr = one_in(24);
    inst_ex     <= inst;
    ex_ctrl     <= c;
    if_valid    <= bits[11] | bits[12];
    de_ready    <= bits[13] | bits[14];
    ex_valid    <= bits[15] | bits[16] | bits[17];
    ex_ready    <= bits[18] | bits[19];
    cmp_true    <= bits[20];
    predicted   <= bits[21];
    prv         <= bits[23:22];
    dmem_hready <= !one_in(4);  // wait states
    imem_badmem <= one_in(8);
    dmem_badmem <= one_in(20);
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      fail_count++;
      $display("[FAIL] %s at cycle %0d expected %0h actual %0h", name, cycle, exp, act);
      $display("Regression failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic compare_outputs();
    model_eval();
    check_value("raw_bypass", 32'(exp_bypass), 32'(bypass));
    check_value("load_use_stall", 32'(exp_load_use), 32'(load_use));
    check_value("dx_stall", 32'(exp_stall_ex), 32'(stall_ex));
    check_value("dx_kill", 32'(exp_kill_ex), 32'(kill_ex));
    check_value("branch_redirect", 32'(exp_redirect), 32'(redirect));
    check_value("pc_source", 32'(exp_pc_src), 32'(pc_src_sel));
    check_value("dmem_write_enable", 32'(exp_dmem_wen), 32'(dmem_wen));
    check_value("dmem_htrans", 32'(exp_htrans), 32'(dmem_htrans));
    check_value("flush", 32'(exp_flush), 32'(flush));
    check_value("wb_write_enable", 32'(exp_wr_reg_wb), 32'(wr_reg_wb));
    check_value("wb_rd", 32'(exp_rd_wb), 32'(rd_wb));
    check_value("wb_source", 32'(exp_wb_src), 32'(wb_src_wb));
    check_value("trap_valid", 32'(exp_exc_valid), 32'(exc[4]));
    if (exp_exc_valid) check_value("trap_cause", 32'(exp_exc_cause), 32'(exc[3:0]));
    check_value("retire", 32'(exp_retire), 32'(retire));
    if (|exp_bypass) n_bypass++;
    if (exp_load_use) n_load_use++;
    if (exp_exc_valid) n_trap++;
    if (exp_retire) n_retire++;
  endtask

  // model flops follow the dut edge
  always @(posedge clk) begin
    cycle++;
    if (!rst_n) model_reset();
    else model_advance();
  end

  always @(negedge clk) begin
    if (cycle > 0) compare_outputs(); // inputs and dut settled mid cycle
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout, the run was still going after %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    inst_ex     = '0;
    ex_ctrl     = '0;
    if_valid    = 1'b0;
    de_ready    = 1'b0;
    ex_valid    = 1'b0;
    ex_ready    = 1'b0;
    imem_badmem = 1'b0;
    dmem_badmem = 1'b0;
    dmem_hready = 1'b1;
    cmp_true    = 1'b0;
    predicted   = 1'b0;
    prv         = 2'd0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      drive_inputs();
    end
    repeat (2) @(posedge clk); // let the last compare run
    $display("cycles %0d bypass %0d load_use %0d traps %0d retired %0d",
             cycle, n_bypass, n_load_use, n_trap, n_retire);
    if (fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
+incdir+test
rtl/rv32_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/operand_hazard.sv
rtl/branch_resolve.sv
rtl/ex_stage_ctrl.sv
rtl/wb_stage_ctrl.sv
rtl/pipeline_ctrl.sv
test/tb_pipeline_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pipeline control regression with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_pipeline_ctrl \
  -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_pipeline_ctrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
  exit 0
fi
exit 1
